//--- Bender.yml
package:
  name: blackjack

sources:
  - logic/blackjack_pkg.sv
  - logic/card_deck.sv
  - logic/hand_store.sv
  - logic/game_sequencer.sv
  - logic/seg_display.sv
  - logic/blackjack_top.sv
  - target: test
    files:
      - dv/blackjack_checker.sv
      - dv/blackjack_tb.sv

//--- blackjack_top.f
logic/blackjack_pkg.sv
logic/card_deck.sv
logic/hand_store.sv
logic/game_sequencer.sv
logic/seg_display.sv
logic/blackjack_top.sv
dv/blackjack_checker.sv
dv/blackjack_tb.sv

//--- dv/blackjack_checker.sv
`timescale 1ns/1ps
// Watches the blackjack DUT ports and rebuilds both hands from the display
// Checks reset, deal timing, hits, the house turn and the outcome; counts errors
module blackjack_checker import blackjack_pkg::*; #(
    parameter int HAND_SIZE = 5
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic               hit,
    input  logic               hand_select,
    input  seg_t [HAND_SIZE:0] digits,
    input  phase_e             phase,
    input  outcome_e           outcome,
    output int                 errors
);

    // Active low owner letters with segment a on bit 0
    localparam seg_t LETTER_P = 7'b0001100;
    localparam seg_t LETTER_H = 7'b0001001;

    // Last decoded view per hand with the player at index 0
    int cnt [2];
    int pts [2];
    bit seen [2];
    bit reset_seen;
    bit dealing;
    int deal_age;
    bit after_deal;
    bit done_checked;
    int hit_expect;
    int draw_cycles;

    // Glyph back to points where tens and faces share the 0 glyph
    function automatic int glyph_points(seg_t g);
        case (g)
            7'b1111111: return 0;
            7'b0001000: return 1;
            7'b0100100: return 2;
            7'b0110000: return 3;
            7'b0011001: return 4;
            7'b0010010: return 5;
            7'b0000010: return 6;
            7'b1111000: return 7;
            7'b0000000: return 8;
            7'b0011000: return 9;
            7'b1000000: return 10;
            default:    return -1;
        endcase
    endfunction

    // Reference result with busts first and the greater total after
    function automatic outcome_e expected_outcome(int player, int house);
        outcome_e res;
        if (player > BLACKJACK) begin
            res = HOUSE_WIN;
        end else if (house > BLACKJACK) begin
            res = PLAYER_WIN;
        end else if (player > house) begin
            res = PLAYER_WIN;
        end else if (player < house) begin
            res = HOUSE_WIN;
        end else begin
            res = DRAW;
        end
        return res;
    endfunction

    // Count and total of the hand now on the card digits
    task automatic decode_shown(output int n, output int total);
        int  p;
        bit  gap;
        n = 0;
        total = 0;
        gap = 0;
        for (int i = 0; i < HAND_SIZE; i++) begin
            p = glyph_points(digits[i]);
            if (p < 0) begin
                $display("** Error: digits[%0d] = 0x%0h, not a card glyph", i, digits[i]);
                errors++;
            end else if (p == 0) begin
                gap = 1;
            end else begin
                if (gap) begin
                    $display("Card shown after an empty slot on digit %0d", i);
                    errors++;
                end
                n++;
                total += p;
            end
        end
    endtask

    // Sampled on the rising edge before any flop updates
    always @(posedge clk) begin
        int n;
        int total;
        int side;
        if (!rst) begin
            errors      = 0;
            seen[0]     = 0;
            seen[1]     = 0;
            dealing     = 0;
            after_deal  = 0;
            hit_expect  = -1;
            draw_cycles = 0;
            done_checked = 1;
        end else begin
            side = hand_select ? 1 : 0;
            decode_shown(n, total);
            if (digits[HAND_SIZE] !== (hand_select ? LETTER_H : LETTER_P)) begin
                $display("** Error: digits[%0d] = 0x%0h, expected 0x%0h",
                         HAND_SIZE, digits[HAND_SIZE], hand_select ? LETTER_H : LETTER_P);
                errors++;
            end
            // First cycle out of reset
            if (!reset_seen) begin
                reset_seen = 1;
                if (phase !== IDLE || outcome !== NONE || n != 0) begin
                    $display({"** Error: phase = 0x%0h outcome = 0x%0h cards = 0x%0h,",
                              " expected 0x%0h 0x%0h 0x0 after reset"},
                             phase, outcome, n, IDLE, NONE);
                    errors++;
                end
            end
            // Deal lasts 12 cycles and the 13th is the player turn
            if (dealing) begin
                deal_age++;
                if (deal_age < 13 && phase !== DEAL) begin
                    $display("** Error: phase = 0x%0h, expected 0x%0h in deal cycle %0d",
                             phase, DEAL, deal_age);
                    errors++;
                end else if (deal_age == 13) begin
                    dealing = 0;
                    if (phase !== PLAYER_WAIT) begin
                        $display("** Error: phase = 0x%0h, expected 0x%0h after deal",
                                 phase, PLAYER_WAIT);
                        errors++;
                    end
                end
            end
            // Hands only change while cards are drawn
            if (phase == PLAYER_WAIT || phase == DONE) begin
                if (seen[side] && n != cnt[side]) begin
                    $display("** Error: hand %0d card count = 0x%0h, expected 0x%0h", side,
                             n, cnt[side]);
                    errors++;
                end
                cnt[side]  = n;
                pts[side]  = total;
                seen[side] = 1;
            end else begin
                seen[0] = 0;
                seen[1] = 0;
            end
            if (phase == PLAYER_WAIT) begin
                if (after_deal && n != 2) begin
                    $display("** Error: hand %0d card count = 0x%0h, expected 0x2", side, n);
                    errors++;
                end
                // 21 and a full hand both stand on their own
                if (side == 0 && (total >= BLACKJACK || n == HAND_SIZE)) begin
                    $display("Player still waiting with %0d points in %0d cards", total, n);
                    errors++;
                end
            end
            // Card count after a hit
            if (hit_expect >= 0 && side == 0 && seen[0]) begin
                if (n != hit_expect) begin
                    $display("** Error: player card count = 0x%0h, expected 0x%0h", n,
                             hit_expect);
                    errors++;
                end
                hit_expect = -1;
            end
            // Three draw cycles plus the check cycle
            if (phase == PLAYER_DRAW) begin
                draw_cycles++;
            end else if (draw_cycles != 0) begin
                if (draw_cycles != 4) begin
                    $display("** Error: hit cycles = 0x%0h, expected 0x4", draw_cycles);
                    errors++;
                end
                draw_cycles = 0;
            end
            if (phase == PLAYER_DRAW || phase == HOUSE_DRAW || phase == DONE) begin
                after_deal = 0;
            end
            // Outcome once both hands have been on the display
            if (phase == DONE && seen[0] && seen[1] && !done_checked) begin
                done_checked = 1;
                if (pts[0] > BLACKJACK && cnt[1] != 2) begin
                    $display("** Error: house card count = 0x%0h, expected 0x2", cnt[1]);
                    errors++;
                end
                if (pts[0] <= BLACKJACK && pts[1] < HOUSE_STAND && cnt[1] != HAND_SIZE) begin
                    $display("** Error: house total = 0x%0h, below 0x%0h", pts[1], HOUSE_STAND);
                    errors++;
                end
                if (outcome !== expected_outcome(pts[0], pts[1])) begin
                    $display("** Error: outcome = 0x%0h, expected 0x%0h", outcome,
                             expected_outcome(pts[0], pts[1]));
                    errors++;
                end
            end
            if (hit && phase == PLAYER_WAIT && seen[0] && cnt[0] < HAND_SIZE) begin
                hit_expect = cnt[0] + 1;
            end
            if (start && (phase == IDLE || phase == DONE)) begin
                if (phase == DONE && !done_checked) begin
                    $display("Game ended without both hands on the display");
                    errors++;
                end
                dealing      = 1;
                deal_age     = 0;
                after_deal   = 1;
                done_checked = 0;
                hit_expect   = -1;
            end
        end
    end

endmodule

//--- dv/blackjack_tb.sv
`timescale 1ns/1ps
// Blackjack testbench top: clock, reset, seeded games, DUT and checker
// Each game deals, takes 0 to 4 random hits, stands and shows both hands
module blackjack_tb import blackjack_pkg::*; ();

    localparam int HAND_SIZE   = 5;
    localparam int GAMES       = 20;
    // About 200 cycles per game covers deal, hits, house turn and display
    localparam int CYCLE_LIMIT = GAMES * 200;

    logic               clk;
    logic               rst;
    logic               start;
    logic               hit;
    logic               stand;
    logic               hand_select;
    logic [SEED_W-1:0]  seed;
    seg_t [HAND_SIZE:0] digits;
    phase_e             phase;
    outcome_e           outcome;
    int                 errors;
    int                 tb_errors;
    int                 cycles;
    int                 seed_init;

    blackjack_top #(
        .HAND_SIZE (HAND_SIZE)
    ) i_dut (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .hit         (hit),
        .stand       (stand),
        .hand_select (hand_select),
        .seed        (seed),
        .digits      (digits),
        .phase       (phase),
        .outcome     (outcome)
    );

    blackjack_checker #(
        .HAND_SIZE (HAND_SIZE)
    ) i_check (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .hit         (hit),
        .hand_select (hand_select),
        .digits      (digits),
        .phase       (phase),
        .outcome     (outcome),
        .errors      (errors)
    );

    // 4 ns period
    always #2 clk = ~clk;

    // Hang guard
    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic skip_cycles(int n);
        repeat (n) @(negedge clk);
    endtask

    // Inputs high for exactly one rising edge
    task automatic pulse_inputs(bit s, bit h, bit st);
        start = s;
        hit   = h;
        stand = st;
        @(negedge clk);
        start = 1'b0;
        hit   = 1'b0;
        stand = 1'b0;
    endtask

    task automatic wait_phase(phase_e target, int limit);
        int n;
        n = 0;
        while (phase != target && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (phase != target) begin
            $display("Phase 0x%0h not reached within %0d cycles", target, limit);
            tb_errors++;
        end
    endtask

    task automatic wait_draw_end(int limit);
        int n;
        n = 0;
        while (phase == PLAYER_DRAW && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (phase == PLAYER_DRAW) begin
            $display("Hit card still not taken after %0d cycles", limit);
            tb_errors++;
        end
    endtask

    // Player hand then house hand for two cycles each
    task automatic show_hands();
        hand_select = 1'b0;
        skip_cycles(2);
        hand_select = 1'b1;
        skip_cycles(2);
        hand_select = 1'b0;
    endtask

    task automatic play_game(int hits);
        pulse_inputs(1, 0, 0);
        // Stray hit and stand while the cards are dealt
        skip_cycles(3);
        pulse_inputs(0, 1, 0);
        pulse_inputs(0, 0, 1);
        wait_phase(PLAYER_WAIT, 20);
        show_hands();
        for (int i = 0; i < hits; i++) begin
            if (phase == PLAYER_WAIT) begin
                pulse_inputs(0, 1, 0);
                // Stand while the hit card is still in flight
                pulse_inputs(0, 0, 1);
                wait_draw_end(10);
                if (phase == PLAYER_WAIT) begin
                    show_hands();
                end
            end
        end
        if (phase == PLAYER_WAIT) begin
            pulse_inputs(0, 0, 1);
        end
        wait_phase(DONE, 100);
        show_hands();
        // Hit after the game is over
        pulse_inputs(0, 1, 0);
        show_hands();
    endtask

    initial begin
        seed_init   = $urandom(4);
        cycles      = 0;
        tb_errors   = 0;
        clk         = 1'b0;
        rst         = 1'b0;
        start       = 1'b0;
        hit         = 1'b0;
        stand       = 1'b0;
        hand_select = 1'b0;
        seed        = SEED_W'($urandom);
        skip_cycles(10);
        rst = 1'b1;
        // Deck shuffles in the first cycle out of reset
        skip_cycles(3);
        for (int g = 0; g < GAMES; g++) begin
            play_game($urandom_range(4, 0));
        end
        skip_cycles(2);
        $display("Errors: checker %0d, testbench %0d", errors, tb_errors);
        if (errors == 0 && tb_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- logic/blackjack_pkg.sv
// Types, constants and card helpers shared by the blackjack table
// Compile before any module; users pull it in with a wildcard import
package blackjack_pkg;

    // Card rank, 0 is an empty slot, 1 ace, 11 to 13 jack queen king
    typedef logic [3:0] card_t;

    // Point total of one hand
    typedef logic [5:0] points_t;

    // Summary of one hand as seen by the sequencer
    typedef struct packed {
        points_t    total;
        logic [2:0] count;
        logic       full;
    } hand_status_t;

    // Game phase visible at the top level
    typedef enum logic [2:0] {
        IDLE,
        DEAL,
        PLAYER_WAIT,
        PLAYER_DRAW,
        HOUSE_DRAW,
        DONE
    } phase_e;

    typedef enum logic [1:0] {
        NONE,
        PLAYER_WIN,
        HOUSE_WIN,
        DRAW
    } outcome_e;

    // Active low digit, bit 0 drives segment a and bit 6 segment g
    typedef logic [6:0] seg_t;

    // Bust above this total
    localparam int BLACKJACK   = 21;
    // House stops drawing at this total
    localparam int HOUSE_STAND = 17;
    localparam int SEED_W      = 6;

    // Letter and blank glyphs
    localparam seg_t SEG_BLANK = 7'b1111111;
    localparam seg_t SEG_P     = 7'b0001100;
    localparam seg_t SEG_H     = 7'b0001001;

    // Ace counts 1, faces clamp to 10
    function automatic points_t card_points(card_t rank);
        if (rank > 4'd10) begin
            return points_t'(10);
        end
        return points_t'(rank);
    endfunction

    // Digit glyph per rank; all tens and faces share the 0 glyph
    function automatic seg_t card_glyph(card_t rank);
        case (rank)
            4'd1:    return 7'b0001000;
            4'd2:    return 7'b0100100;
            4'd3:    return 7'b0110000;
            4'd4:    return 7'b0011001;
            4'd5:    return 7'b0010010;
            4'd6:    return 7'b0000010;
            4'd7:    return 7'b1111000;
            4'd8:    return 7'b0000000;
            4'd9:    return 7'b0011000;
            4'd10, 4'd11, 4'd12, 4'd13: return 7'b1000000;
            default: return SEG_BLANK;
        endcase
    endfunction

endpackage

//--- logic/blackjack_top.sv
`timescale 1ns/1ps
// Blackjack table top level: deck, player and house hands, FSM, display
// HAND_SIZE is set here and passed to every block that holds cards
module blackjack_top import blackjack_pkg::*; #(
    parameter int HAND_SIZE = 5
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic              hit,
    input  logic              stand,
    input  logic              hand_select,
    input  logic [SEED_W-1:0] seed,
    output seg_t [HAND_SIZE:0] digits,
    output phase_e            phase,
    output outcome_e          outcome
);

    // Deck handshake
    logic  shuffle_start;
    logic  deck_ready;
    logic  draw_req;
    logic  card_valid;
    card_t card;

    // Hand path
    logic                  player_take;
    logic                  house_take;
    logic                  hand_clear;
    card_t [HAND_SIZE-1:0] player_hand;
    card_t [HAND_SIZE-1:0] house_hand;
    hand_status_t          player_status;
    hand_status_t          house_status;

    card_deck i_deck (
        .clk           (clk),
        .rst           (rst),
        .shuffle_start (shuffle_start),
        .seed          (seed),
        .draw_req      (draw_req),
        .deck_ready    (deck_ready),
        .card_valid    (card_valid),
        .card          (card)
    );

    hand_store #(
        .HAND_SIZE (HAND_SIZE)
    ) i_player (
        .clk    (clk),
        .rst    (rst),
        .clear  (hand_clear),
        .take   (player_take),
        .card   (card),
        .hand   (player_hand),
        .status (player_status)
    );

    hand_store #(
        .HAND_SIZE (HAND_SIZE)
    ) i_house (
        .clk    (clk),
        .rst    (rst),
        .clear  (hand_clear),
        .take   (house_take),
        .card   (card),
        .hand   (house_hand),
        .status (house_status)
    );

    game_sequencer #(
        .HAND_SIZE (HAND_SIZE)
    ) i_seq (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .hit           (hit),
        .stand         (stand),
        .deck_ready    (deck_ready),
        .card_valid    (card_valid),
        .player_status (player_status),
        .house_status  (house_status),
        .shuffle_start (shuffle_start),
        .draw_req      (draw_req),
        .player_take   (player_take),
        .house_take    (house_take),
        .hand_clear    (hand_clear),
        .phase         (phase),
        .outcome       (outcome)
    );

    seg_display #(
        .HAND_SIZE (HAND_SIZE)
    ) i_disp (
        .hand_select (hand_select),
        .player_hand (player_hand),
        .house_hand  (house_hand),
        .digits      (digits)
    );

endmodule

//--- logic/card_deck.sv
`timescale 1ns/1ps
// Pseudo-random card source built on a 16-bit Galois LFSR
// shuffle_start loads the seed; each draw_req gets one card two cycles later
module card_deck import blackjack_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              shuffle_start,
    input  logic [SEED_W-1:0] seed,
    input  logic              draw_req,
    output logic              deck_ready,
    output logic              card_valid,
    output card_t             card
);

    // Taps for x^16 + x^14 + x^13 + x^11 + 1
    localparam logic [15:0] TAPS      = 16'hB400;
    // Stand-in for an all-zero seed, which would lock the LFSR
    localparam logic [15:0] ZERO_SEED = 16'hACE1;

    logic [15:0] lfsr;
    logic [15:0] lfsr_next;
    logic [15:0] seed_word;
    logic [15:0] rank_wide;
    logic        req_q;

    // One right shift, feedback folded into the tap positions
    assign lfsr_next = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? TAPS : 16'h0000);

    // Replicate the seed bits so the upper stages start populated
    assign seed_word = (seed == '0) ? ZERO_SEED
                     : {seed, seed, seed[SEED_W-1 -: 16 - 2 * SEED_W]};

    // Rank 1..13 from the LFSR state
    assign rank_wide = (lfsr % 16'd13) + 16'd1;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lfsr       <= ZERO_SEED;
            deck_ready <= 1'b0;
            req_q      <= 1'b0;
            card_valid <= 1'b0;
        end else begin
            if (shuffle_start) begin
                lfsr       <= seed_word;
                deck_ready <= 1'b1;
            end else if (draw_req) begin
                // Advance once per draw
                lfsr <= lfsr_next;
            end
            // Two stage reply: advance, then register the rank
            req_q      <= draw_req;
            card_valid <= req_q;
        end
    end

    // Card held stable through its valid cycle
    always_ff @(posedge clk) begin
        if (req_q) begin
            card <= rank_wide[3:0];
        end
    end

endmodule

//--- logic/game_sequencer.sv
`timescale 1ns/1ps
// Game FSM: shuffle after reset, deal four cards, player turn, house turn
// Draws go through the deck request/valid handshake; outcome is set on DONE
module game_sequencer import blackjack_pkg::*; #(
    parameter int HAND_SIZE = 5
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         start,
    input  logic         hit,
    input  logic         stand,
    input  logic         deck_ready,
    input  logic         card_valid,
    input  hand_status_t player_status,
    input  hand_status_t house_status,
    output logic         shuffle_start,
    output logic         draw_req,
    output logic         player_take,
    output logic         house_take,
    output logic         hand_clear,
    output phase_e       phase,
    output outcome_e     outcome
);

    // Internal states, one more than the visible phases
    typedef enum logic [2:0] {
        S_IDLE,
        S_DEAL,
        S_PLAYER_WAIT,
        S_PLAYER_DRAW,
        S_PLAYER_CHECK,
        S_HOUSE_DRAW,
        S_DONE
    } state_e;

    state_e     state;
    logic       shuffled;
    logic       pending;
    logic [1:0] deal_cnt;
    logic       house_wants;
    logic       player_room;

    // Bust first, then the higher total wins
    function automatic outcome_e decide(points_t player, points_t house);
        if (player > BLACKJACK) begin
            return HOUSE_WIN;
        end
        if (house > BLACKJACK) begin
            return PLAYER_WIN;
        end
        if (player > house) begin
            return PLAYER_WIN;
        end
        if (player < house) begin
            return HOUSE_WIN;
        end
        return DRAW;
    endfunction

    // Single shuffle right after reset
    assign shuffle_start = !shuffled;

    assign house_wants = (house_status.total < points_t'(HOUSE_STAND)) && !house_status.full;
    assign player_room = (player_status.count < 3'(HAND_SIZE));

    // Request only with no card in flight
    always_comb begin
        draw_req = 1'b0;
        if (deck_ready && !pending) begin
            case (state)
                S_DEAL, S_PLAYER_DRAW: draw_req = 1'b1;
                S_HOUSE_DRAW:          draw_req = house_wants;
                default:               draw_req = 1'b0;
            endcase
        end
    end

    // Deal order is player, house, player, house
    assign player_take = card_valid &&
                         (state == S_PLAYER_DRAW || (state == S_DEAL && !deal_cnt[0]));
    assign house_take  = card_valid &&
                         (state == S_HOUSE_DRAW || (state == S_DEAL && deal_cnt[0]));

    always_comb begin
        case (state)
            S_DEAL:                        phase = DEAL;
            S_PLAYER_WAIT:                 phase = PLAYER_WAIT;
            // The bust check still belongs to the hit
            S_PLAYER_DRAW, S_PLAYER_CHECK: phase = PLAYER_DRAW;
            S_HOUSE_DRAW:                  phase = HOUSE_DRAW;
            S_DONE:                        phase = DONE;
            default:                       phase = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state      <= S_IDLE;
            shuffled   <= 1'b0;
            pending    <= 1'b0;
            deal_cnt   <= '0;
            hand_clear <= 1'b0;
            outcome    <= NONE;
        end else begin
            shuffled   <= 1'b1;
            hand_clear <= 1'b0;
            if (draw_req) begin
                pending <= 1'b1;
            end else if (card_valid) begin
                pending <= 1'b0;
            end
            case (state)
                // DONE keeps the result shown until the next start
                S_IDLE, S_DONE: begin
                    if (start && deck_ready) begin
                        state      <= S_DEAL;
                        deal_cnt   <= '0;
                        hand_clear <= 1'b1;
                        outcome    <= NONE;
                    end
                end
                S_DEAL: begin
                    if (card_valid) begin
                        deal_cnt <= deal_cnt + 2'd1;
                        if (deal_cnt == 2'd3) begin
                            state <= S_PLAYER_WAIT;
                        end
                    end
                end
                S_PLAYER_WAIT: begin
                    if (hit && player_room) begin
                        state <= S_PLAYER_DRAW;
                    end else if (stand) begin
                        state <= S_HOUSE_DRAW;
                    end
                end
                S_PLAYER_DRAW: begin
                    if (card_valid) begin
                        state <= S_PLAYER_CHECK;
                    end
                end
                // Status now holds the new card
                S_PLAYER_CHECK: begin
                    if (player_status.total > BLACKJACK) begin
                        state   <= S_DONE;
                        outcome <= decide(player_status.total, house_status.total);
                    end else if (player_status.total == BLACKJACK || player_status.full) begin
                        state <= S_HOUSE_DRAW;
                    end else begin
                        state <= S_PLAYER_WAIT;
                    end
                end
                // Re-evaluated each cycle once no card is in flight
                S_HOUSE_DRAW: begin
                    if (!pending && !house_wants) begin
                        state   <= S_DONE;
                        outcome <= decide(player_status.total, house_status.total);
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

//--- logic/hand_store.sv
`timescale 1ns/1ps
// Holds one hand: card slots, card count and running point total
// One instance for the player and one for the house
module hand_store import blackjack_pkg::*; #(
    parameter int HAND_SIZE = 5
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  clear,
    input  logic                  take,
    input  card_t                 card,
    output card_t [HAND_SIZE-1:0] hand,
    output hand_status_t          status
);

    logic [2:0] count;
    points_t    total;
    logic       full;

    // No free slot left
    assign full = (count == 3'(HAND_SIZE));

    assign status = '{total: total, count: count, full: full};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            hand  <= '0;
            count <= '0;
            total <= '0;
        end else if (clear) begin
            // New game, all slots back to empty
            hand  <= '0;
            count <= '0;
            total <= '0;
        end else if (take && !full) begin
            // Append into the next empty slot
            hand[count] <= card;
            count       <= count + 3'd1;
            total       <= total + card_points(card);
        end
    end

endmodule

//--- logic/seg_display.sv
`timescale 1ns/1ps
// Seven-segment view of one hand, picked by hand_select
// Low digits show cards, the top digit shows P or H
module seg_display import blackjack_pkg::*; #(
    parameter int HAND_SIZE = 5
) (
    input  logic                  hand_select,
    input  card_t [HAND_SIZE-1:0] player_hand,
    input  card_t [HAND_SIZE-1:0] house_hand,
    output seg_t  [HAND_SIZE:0]   digits
);

    // Hand on display
    card_t [HAND_SIZE-1:0] shown;

    // Low selects the player, high the house
    assign shown = hand_select ? house_hand : player_hand;

    always_comb begin
        // First card on digit 0
        for (int i = 0; i < HAND_SIZE; i++) begin
            digits[i] = card_glyph(shown[i]);
        end
        // Owner letter
        digits[HAND_SIZE] = hand_select ? SEG_H : SEG_P;
    end

endmodule
